//--- common/frv_exec_pkg.sv
/*
 * Shared types and codes for the execute stage.
 * Holds the data word, functional unit select, micro-op codes, the ALU
 * operation enum and the control payload carried towards writeback.
 */
package frv_exec_pkg;

    localparam int XLEN = 32;                     // Data word width

    typedef logic [XLEN-1:0] xword_t;             // One data word
    typedef logic [4:0]      fu_t;                // One-hot unit select
    typedef logic [4:0]      uop_t;               // Micro-op code

    // Functional unit bit positions ------------------------------------------
    localparam int FU_ALU = 0;
    localparam int FU_MUL = 1;
    localparam int FU_LSU = 2;
    localparam int FU_CFU = 3;
    localparam int FU_CSR = 4;

    // ALU micro-ops
    localparam uop_t ALU_ADD  = 5'b00000;
    localparam uop_t ALU_SUB  = 5'b00001;
    localparam uop_t ALU_XOR  = 5'b00010;
    localparam uop_t ALU_OR   = 5'b00011;
    localparam uop_t ALU_AND  = 5'b00100;
    localparam uop_t ALU_SLL  = 5'b00101;
    localparam uop_t ALU_SRL  = 5'b00110;
    localparam uop_t ALU_SRA  = 5'b00111;
    localparam uop_t ALU_SLT  = 5'b01000;
    localparam uop_t ALU_SLTU = 5'b01001;

    // Control flow micro-ops, conditional branches in the 00xxx range
    localparam uop_t CFU_BEQ       = 5'b00001;
    localparam uop_t CFU_BNE       = 5'b00010;
    localparam uop_t CFU_BLT       = 5'b00011;
    localparam uop_t CFU_BGE       = 5'b00100;
    localparam uop_t CFU_BLTU      = 5'b00101;
    localparam uop_t CFU_BGEU      = 5'b00110;
    localparam uop_t CFU_JALR      = 5'b10001;
    localparam uop_t CFU_JALI      = 5'b10010;
    localparam uop_t CFU_TAKEN     = 5'b11001;   // Resolved branch, taken
    localparam uop_t CFU_NOT_TAKEN = 5'b11000;   // Resolved branch, fall through

    // Multiply micro-ops
    localparam uop_t MUL_MUL    = 5'b00000;
    localparam uop_t MUL_MULH   = 5'b00001;
    localparam uop_t MUL_MULHU  = 5'b00010;
    localparam uop_t MUL_MULHSU = 5'b00011;

    // LSU uop flag bits
    localparam int LSU_LOAD  = 3;
    localparam int LSU_STORE = 4;

    // Operation handed to the ALU, already decoded from the uop
    typedef enum logic [3:0] {
        AOP_ADD,
        AOP_SUB,
        AOP_XOR,
        AOP_OR,
        AOP_AND,
        AOP_SLL,
        AOP_SRL,
        AOP_SRA,
        AOP_SLT                                   // Signedness from is_unsigned
    } alu_op_t;

    // Control payload towards writeback, 49 bits
    typedef struct packed {
        logic [4:0]  rd;                          // Destination register
        uop_t        uop;                         // Possibly rewritten uop
        fu_t         fu;                          // Unit that executed it
        logic [1:0]  size;                        // Instruction size
        logic [31:0] instr;                       // Instruction word
    } exec_ctrl_t;

endpackage

//--- common/alu_if.sv
/*
 * Combinational link between the result selector and the integer ALU.
 * The selector drives operands and operation, the ALU returns results.
 */
`timescale 1ns/1ps

interface alu_if;
    import frv_exec_pkg::*;

    xword_t  lhs;                                 // Left operand
    xword_t  rhs;                                 // Right operand
    alu_op_t op;                                  // Decoded operation
    logic    is_unsigned;                         // Unsigned compare
    xword_t  result;                              // Operation result
    xword_t  add_result;                          // Raw lhs + rhs
    logic    lt;                                  // lhs < rhs
    logic    eq;                                  // lhs == rhs

    modport sel (output lhs, rhs, op, is_unsigned, input result, add_result, lt, eq);
    modport alu (input lhs, rhs, op, is_unsigned, output result, add_result, lt, eq);

endinterface

//--- common/imul_if.sv
/*
 * Request/response link between the result selector and the multiplier.
 * ready stays high with the product until clear returns the unit to idle.
 */
`timescale 1ns/1ps

interface imul_if;
    import frv_exec_pkg::*;

    logic        valid;                           // Multiply presented
    uop_t        uop;                             // Which multiply
    xword_t      rs1;                             // Source 1
    xword_t      rs2;                             // Source 2
    logic        clear;                           // Progress or flush
    logic        ready;                           // Product complete
    logic [63:0] result;                          // Full product

    modport sel  (output valid, uop, rs1, rs2, clear, input ready, result);
    modport imul (input valid, uop, rs1, rs2, clear, output ready, result);

endinterface

//--- verilog/frv_alu.sv
/*
 * Single-cycle integer ALU.
 * Add, subtract, logic ops, shifts and set-less-than, plus the compare
 * flags and raw sum used for branches and address generation.
 */
`timescale 1ns/1ps

module frv_alu (
    input  logic g_clk,
    input  logic g_resetn,
    alu_if.alu   alu
);
    import frv_exec_pkg::*;

    logic [4:0] shamt;                            // Low 5 bits of rhs

    assign shamt          = alu.rhs[4:0];
    assign alu.add_result = alu.lhs + alu.rhs;    // Also the LSU/JALR address
    assign alu.eq         = alu.lhs == alu.rhs;
    assign alu.lt         = alu.is_unsigned ? (alu.lhs < alu.rhs) :
                                              ($signed(alu.lhs) < $signed(alu.rhs));

    // Result select -----------------------------------------------------------
    always_comb begin
        case (alu.op)
            AOP_ADD: alu.result = alu.add_result;
            AOP_SUB: alu.result = alu.lhs - alu.rhs;
            AOP_XOR: alu.result = alu.lhs ^ alu.rhs;
            AOP_OR:  alu.result = alu.lhs | alu.rhs;
            AOP_AND: alu.result = alu.lhs & alu.rhs;
            AOP_SLL: alu.result = alu.lhs << shamt;
            AOP_SRL: alu.result = alu.lhs >> shamt;
            AOP_SRA: alu.result = xword_t'($signed(alu.lhs) >>> shamt);
            AOP_SLT: alu.result = {{(XLEN-1){1'b0}}, alu.lt};
            default: alu.result = alu.add_result;
        endcase
    end

    // Selector hands over only defined operations
    a_op_legal: assert property (@(posedge g_clk) disable iff (!g_resetn)
        alu.op <= AOP_SLT);

    // Unsigned compare only with set-less-than or branch flags
    a_unsigned_cmp: assert property (@(posedge g_clk) disable iff (!g_resetn)
        alu.is_unsigned |-> (alu.op == AOP_SLT || alu.op == AOP_SUB));

endmodule

//--- imul/frv_imul.sv
/*
 * Iterative radix-2 shift-add multiplier for mul, mulh, mulhu, mulhsu.
 * Multiplies operand magnitudes over 32 cycles and fixes the sign at the
 * output. The product is held with ready until clear.
 */
`timescale 1ns/1ps

module frv_imul (
    input  logic g_clk,
    input  logic g_resetn,
    imul_if.imul mul
);
    import frv_exec_pkg::*;

    logic        run;                             // Iterating
    logic        done;                            // Product held
    logic        start;                           // Idle and request seen
    logic        neg;                             // Negate magnitude product
    logic [4:0]  count;                           // Iteration count
    logic        a_signed;                        // rs1 taken as signed
    logic        b_signed;                        // rs2 taken as signed
    xword_t      a_mag;                           // |rs1|
    xword_t      b_mag;                           // |rs2|
    xword_t      mcand;                           // Multiplicand magnitude
    xword_t      acc;                             // Upper product half
    xword_t      mplr;                            // Multiplier, low bits shift in
    logic [32:0] step_sum;                        // Partial sum with carry
    logic [63:0] prod;                            // Magnitude product

    assign a_signed = mul.uop != MUL_MULHU;
    assign b_signed = mul.uop == MUL_MUL || mul.uop == MUL_MULH;
    assign a_mag    = (a_signed && mul.rs1[31]) ? -mul.rs1 : mul.rs1;
    assign b_mag    = (b_signed && mul.rs2[31]) ? -mul.rs2 : mul.rs2;
    assign start    = !run && !done && mul.valid;
    assign step_sum = {1'b0, acc} + (mplr[0] ? {1'b0, mcand} : 33'd0);
    assign prod     = {acc, mplr};

    // Control ----------------------------------------------------------------
    always_ff @(posedge g_clk) begin
        if (!g_resetn || mul.clear) begin
            run   <= 1'b0;
            done  <= 1'b0;
            count <= '0;
        end else if (start) begin
            run   <= 1'b1;
            count <= '0;
        end else if (run) begin
            count <= count + 5'd1;
            if (count == 5'd31) begin              // Last partial product
                run  <= 1'b0;
                done <= 1'b1;
            end
        end
    end

    // Datapath
    always_ff @(posedge g_clk) begin
        if (start) begin
            neg   <= (a_signed && mul.rs1[31]) ^ (b_signed && mul.rs2[31]);
            mcand <= a_mag;
            acc   <= '0;
            mplr  <= b_mag;
        end else if (run) begin
            acc  <= step_sum[32:1];               // Shift sum right one place
            mplr <= {step_sum[0], mplr[31:1]};
        end
    end

    assign mul.ready  = done;
    assign mul.result = neg ? -prod : prod;       // Sign fix on the way out

    // Completion only ever follows an iteration
    a_ready_after_run: assert property (@(posedge g_clk) disable iff (!g_resetn)
        $rose(mul.ready) |-> $past(run));

endmodule

//--- verilog/frv_exec_select.sv
/*
 * Execute stage decode and result selection.
 * Drives the ALU and multiplier, resolves branches, forms the next s3
 * operands and load enables, and computes stall and forwarding outputs.
 */
`timescale 1ns/1ps

module frv_exec_select (
    input  logic                     g_clk,
    input  logic                     g_resetn,
    input  logic                     i_s2_valid,
    input  logic [4:0]               i_s2_rd,
    input  frv_exec_pkg::xword_t     i_s2_opr_a,
    input  frv_exec_pkg::xword_t     i_s2_opr_b,
    input  frv_exec_pkg::xword_t     i_s2_opr_c,
    input  frv_exec_pkg::uop_t       i_s2_uop,
    input  frv_exec_pkg::fu_t        i_s2_fu,
    input  logic [1:0]               i_s2_size,
    input  logic [31:0]              i_s2_instr,
    input  logic                     i_flush,
    input  logic                     i_p_busy,    // Control register busy
    output logic                     o_s2_busy,
    output logic                     o_p_valid,
    output frv_exec_pkg::exec_ctrl_t o_ctrl,
    output frv_exec_pkg::xword_t     o_opr_a,
    output frv_exec_pkg::xword_t     o_opr_b,
    output logic                     o_ld_a,
    output logic                     o_ld_b,
    output logic [4:0]               o_fwd_rd,
    output frv_exec_pkg::xword_t     o_fwd_wdata,
    output logic                     o_fwd_load,
    output logic                     o_fwd_csr,
    alu_if.sel                       alu,
    imul_if.sel                      mul
);
    import frv_exec_pkg::*;

    logic   fu_alu;
    logic   fu_mul;
    logic   fu_lsu;
    logic   fu_cfu;
    logic   fu_csr;
    logic   lsu_load;
    logic   lsu_store;
    logic   cfu_cond;                             // Conditional branch
    logic   cfu_taken;
    xword_t jump_tgt;                             // Even branch/jump target
    xword_t mul_word;                             // Selected product half
    uop_t   n_uop;

    assign fu_alu    = i_s2_fu[FU_ALU];
    assign fu_mul    = i_s2_fu[FU_MUL];
    assign fu_lsu    = i_s2_fu[FU_LSU];
    assign fu_cfu    = i_s2_fu[FU_CFU];
    assign fu_csr    = i_s2_fu[FU_CSR];
    assign lsu_load  = fu_lsu && i_s2_uop[LSU_LOAD];
    assign lsu_store = fu_lsu && i_s2_uop[LSU_STORE];

    // ALU drive --------------------------------------------------------------
    assign alu.lhs = i_s2_opr_a;
    assign alu.rhs = i_s2_opr_b;

    always_comb begin
        alu.op          = AOP_ADD;                // LSU and JALR use the sum
        alu.is_unsigned = 1'b0;
        if (fu_alu) begin
            case (i_s2_uop)
                ALU_SUB:  alu.op = AOP_SUB;
                ALU_XOR:  alu.op = AOP_XOR;
                ALU_OR:   alu.op = AOP_OR;
                ALU_AND:  alu.op = AOP_AND;
                ALU_SLL:  alu.op = AOP_SLL;
                ALU_SRL:  alu.op = AOP_SRL;
                ALU_SRA:  alu.op = AOP_SRA;
                ALU_SLT:  alu.op = AOP_SLT;
                ALU_SLTU: begin
                    alu.op          = AOP_SLT;
                    alu.is_unsigned = 1'b1;
                end
                default:  alu.op = AOP_ADD;
            endcase
        end else if (fu_cfu) begin
            alu.op          = AOP_SUB;            // Flags only
            alu.is_unsigned = i_s2_uop == CFU_BLTU || i_s2_uop == CFU_BGEU;
        end
    end

    // Branch resolution
    always_comb begin
        cfu_cond = fu_cfu;
        case (i_s2_uop)
            CFU_BEQ:           cfu_taken = alu.eq;
            CFU_BNE:           cfu_taken = !alu.eq;
            CFU_BLT, CFU_BLTU: cfu_taken = alu.lt;
            CFU_BGE, CFU_BGEU: cfu_taken = !alu.lt;
            default: begin                        // Jumps keep their uop
                cfu_cond  = 1'b0;
                cfu_taken = 1'b0;
            end
        endcase
    end

    assign jump_tgt = (i_s2_uop == CFU_JALR) ? {alu.add_result[XLEN-1:1], 1'b0} :
                                               {i_s2_opr_c[XLEN-1:1], 1'b0};
    assign n_uop    = cfu_cond ? (cfu_taken ? CFU_TAKEN : CFU_NOT_TAKEN) : i_s2_uop;

    // Multiplier drive
    assign mul.valid = i_s2_valid && fu_mul;
    assign mul.uop   = i_s2_uop;
    assign mul.rs1   = i_s2_opr_a;
    assign mul.rs2   = i_s2_opr_b;
    assign mul.clear = o_p_valid || i_flush;      // Drop state once consumed
    assign mul_word  = (i_s2_uop == MUL_MUL) ? mul.result[31:0] : mul.result[63:32];

    // Next s3 values ---------------------------------------------------------
    assign o_opr_a = {XLEN{fu_alu}} & alu.result     |
                     {XLEN{fu_mul}} & mul_word       |
                     {XLEN{fu_lsu}} & alu.add_result |
                     {XLEN{fu_cfu}} & jump_tgt       |
                     {XLEN{fu_csr}} & i_s2_opr_a;
    assign o_opr_b = fu_mul ? mul.result[63:32] : i_s2_opr_c; // Store data or CSR

    assign o_ctrl  = '{rd: i_s2_rd, uop: n_uop, fu: i_s2_fu, size: i_s2_size,
                       instr: i_s2_instr};

    // Stall and load enables
    assign o_s2_busy = i_p_busy || (mul.valid && !mul.ready);
    assign o_p_valid = i_s2_valid && !o_s2_busy;
    assign o_ld_a    = o_p_valid && (|i_s2_fu);
    assign o_ld_b    = o_p_valid && (lsu_store || fu_csr || fu_mul);

    // Forwarding for the instruction in execute
    assign o_fwd_rd    = i_s2_rd;
    assign o_fwd_wdata = o_opr_a;
    assign o_fwd_load  = i_s2_valid && lsu_load;
    assign o_fwd_csr   = i_s2_valid && fu_csr;

    a_fu_onehot: assert property (@(posedge g_clk) disable iff (!g_resetn)
        i_s2_valid |-> $onehot(i_s2_fu));

endmodule

//--- verilog/frv_pipeline_register.sv
/*
 * Valid/busy stage register, generic over its payload type.
 * Loads on i_valid while not busy, holds while downstream is busy.
 */
`timescale 1ns/1ps

module frv_pipeline_register #(
    parameter type PAYLOAD_T = logic [31:0]
) (
    input  logic     g_clk,
    input  logic     g_resetn,
    input  logic     i_flush,                     // Drop the held item
    input  logic     i_valid,                     // Load request
    input  PAYLOAD_T i_data,
    output logic     o_busy,                      // Cannot accept this cycle
    output logic     o_valid,
    output PAYLOAD_T o_data,
    input  logic     i_busy                       // Downstream stalled
);

    assign o_busy = o_valid && i_busy;            // Full and not draining

    always_ff @(posedge g_clk) begin
        if (!g_resetn || i_flush) begin
            o_valid <= 1'b0;
        end else if (!o_busy) begin
            o_valid <= i_valid;
        end
    end

    always_ff @(posedge g_clk) begin
        if (i_valid && !o_busy) begin
            o_data <= i_data;
        end
    end

    // Held output must not move under back-pressure
    a_hold: assert property (@(posedge g_clk) disable iff (!g_resetn)
        o_valid && i_busy |=> $stable(o_data));

endmodule

//--- verilog/frv_pipeline_execute.sv
/*
 * Execute stage top level.
 * Takes one decoded instruction per s2 handshake, computes its result in
 * the ALU, CFU, LSU, CSR or multiplier path and registers it towards s3.
 */
`timescale 1ns/1ps

module frv_pipeline_execute (
    input  logic                 g_clk,
    input  logic                 g_resetn,
    input  logic                 i_s2_valid,
    input  logic [4:0]           i_s2_rd,
    input  frv_exec_pkg::xword_t i_s2_opr_a,
    input  frv_exec_pkg::xword_t i_s2_opr_b,
    input  frv_exec_pkg::xword_t i_s2_opr_c,
    input  frv_exec_pkg::uop_t   i_s2_uop,
    input  frv_exec_pkg::fu_t    i_s2_fu,
    input  logic [1:0]           i_s2_size,
    input  logic [31:0]          i_s2_instr,
    output logic                 o_s2_busy,       // Back to decode
    input  logic                 i_flush,
    output logic                 o_s3_valid,
    output logic [4:0]           o_s3_rd,
    output frv_exec_pkg::xword_t o_s3_opr_a,
    output frv_exec_pkg::xword_t o_s3_opr_b,
    output frv_exec_pkg::uop_t   o_s3_uop,
    output frv_exec_pkg::fu_t    o_s3_fu,
    output logic [1:0]           o_s3_size,
    output logic [31:0]          o_s3_instr,
    input  logic                 i_s3_busy,       // From writeback
    output logic [4:0]           o_fwd_rd,
    output frv_exec_pkg::xword_t o_fwd_wdata,
    output logic                 o_fwd_load,
    output logic                 o_fwd_csr
);
    import frv_exec_pkg::*;

    logic       p_valid;                          // Progress into s3
    logic       p_busy;                           // Control register full
    logic       ld_a;
    logic       ld_b;
    exec_ctrl_t n_ctrl;
    exec_ctrl_t s3_ctrl;
    xword_t     n_opr_a;
    xword_t     n_opr_b;

    alu_if  u_alu_if ();
    imul_if u_imul_if ();

    // Decode, select and stall ---------------------------------------------------
    frv_exec_select u_select (
        .g_clk      (g_clk),
        .g_resetn   (g_resetn),
        .i_s2_valid (i_s2_valid),
        .i_s2_rd    (i_s2_rd),
        .i_s2_opr_a (i_s2_opr_a),
        .i_s2_opr_b (i_s2_opr_b),
        .i_s2_opr_c (i_s2_opr_c),
        .i_s2_uop   (i_s2_uop),
        .i_s2_fu    (i_s2_fu),
        .i_s2_size  (i_s2_size),
        .i_s2_instr (i_s2_instr),
        .i_flush    (i_flush),
        .i_p_busy   (p_busy),
        .o_s2_busy  (o_s2_busy),
        .o_p_valid  (p_valid),
        .o_ctrl     (n_ctrl),
        .o_opr_a    (n_opr_a),
        .o_opr_b    (n_opr_b),
        .o_ld_a     (ld_a),
        .o_ld_b     (ld_b),
        .o_fwd_rd   (o_fwd_rd),
        .o_fwd_wdata(o_fwd_wdata),
        .o_fwd_load (o_fwd_load),
        .o_fwd_csr  (o_fwd_csr),
        .alu        (u_alu_if.sel),
        .mul        (u_imul_if.sel)
    );

    frv_alu u_alu (.g_clk(g_clk), .g_resetn(g_resetn), .alu(u_alu_if.alu));

    frv_imul u_imul (.g_clk(g_clk), .g_resetn(g_resetn), .mul(u_imul_if.imul));

    // Stage registers, control carries the handshake
    frv_pipeline_register #(.PAYLOAD_T(exec_ctrl_t)) u_reg_ctrl (
        .g_clk(g_clk), .g_resetn(g_resetn), .i_flush(i_flush),
        .i_valid(p_valid), .i_data(n_ctrl), .o_busy(p_busy),
        .o_valid(o_s3_valid), .o_data(s3_ctrl), .i_busy(i_s3_busy)
    );

    frv_pipeline_register #(.PAYLOAD_T(xword_t)) u_reg_opr_a (
        .g_clk(g_clk), .g_resetn(g_resetn), .i_flush(i_flush),
        .i_valid(ld_a), .i_data(n_opr_a), .o_busy(),
        .o_valid(), .o_data(o_s3_opr_a), .i_busy(i_s3_busy)
    );

    frv_pipeline_register #(.PAYLOAD_T(xword_t)) u_reg_opr_b (
        .g_clk(g_clk), .g_resetn(g_resetn), .i_flush(i_flush),
        .i_valid(ld_b), .i_data(n_opr_b), .o_busy(),
        .o_valid(), .o_data(o_s3_opr_b), .i_busy(i_s3_busy)  // Keeps value otherwise
    );

    assign o_s3_rd    = s3_ctrl.rd;
    assign o_s3_uop   = s3_ctrl.uop;
    assign o_s3_fu    = s3_ctrl.fu;
    assign o_s3_size  = s3_ctrl.size;
    assign o_s3_instr = s3_ctrl.instr;

endmodule

//--- sim/exec_model.svh
/*
 * Reference model of the results the execute stage hands to s3.
 * Included in the testbench module body after the package import.
 */
`ifndef EXEC_MODEL_SVH
`define EXEC_MODEL_SVH

// One expected s3 item
typedef struct packed {
    logic [4:0]  rd;
    uop_t        uop;
    fu_t         fu;
    logic [1:0]  size;
    logic [31:0] instr;
    xword_t      opr_a;
    xword_t      opr_b;
    logic        ld_b;                            // Instruction writes opr_b
    logic        chk_b;                           // opr_b has a defined value
} expect_t;

function automatic xword_t alu_value(input uop_t uop, input xword_t a, input xword_t b);
    case (uop)
        ALU_SUB:  return a - b;
        ALU_XOR:  return a ^ b;
        ALU_OR:   return a | b;
        ALU_AND:  return a & b;
        ALU_SLL:  return a << b[4:0];
        ALU_SRL:  return a >> b[4:0];
        ALU_SRA:  return xword_t'($signed(a) >>> b[4:0]);
        ALU_SLT:  return {31'd0, $signed(a) < $signed(b)};
        ALU_SLTU: return {31'd0, a < b};
        default:  return a + b;
    endcase
endfunction

function automatic logic branch_taken(input uop_t uop, input xword_t a, input xword_t b);
    case (uop)
        CFU_BEQ:  return a == b;
        CFU_BNE:  return a != b;
        CFU_BLT:  return $signed(a) < $signed(b);
        CFU_BGE:  return !($signed(a) < $signed(b));
        CFU_BLTU: return a < b;
        default:  return !(a < b);                // BGEU
    endcase
endfunction

// Full 64-bit product, operands extended per variant
function automatic logic [63:0] mul_product(input uop_t uop, input xword_t a, input xword_t b);
    logic [63:0] ea;
    logic [63:0] eb;
    ea = (uop == MUL_MULHU) ? {32'd0, a} : {{32{a[31]}}, a};
    eb = (uop == MUL_MULHU || uop == MUL_MULHSU) ? {32'd0, b} : {{32{b[31]}}, b};
    return ea * eb;
endfunction

function automatic expect_t expect_result(input logic [4:0] rd, input xword_t a,
                                          input xword_t b, input xword_t c, input uop_t uop,
                                          input fu_t fu, input logic [1:0] size,
                                          input logic [31:0] instr);
    expect_t     e;
    logic [63:0] p;
    xword_t      sum;
    sum = a + b;
    e = '{rd: rd, uop: uop, fu: fu, size: size, instr: instr, opr_a: a, opr_b: c,
          ld_b: 1'b0, chk_b: 1'b0};
    if (fu[FU_ALU]) begin
        e.opr_a = alu_value(uop, a, b);
    end else if (fu[FU_MUL]) begin
        p       = mul_product(uop, a, b);
        e.opr_a = (uop == MUL_MUL) ? p[31:0] : p[63:32];
        e.opr_b = p[63:32];
        e.ld_b  = 1'b1;
    end else if (fu[FU_LSU]) begin
        e.opr_a = sum;                            // Address
        e.ld_b  = uop[LSU_STORE];                 // Store data from opr_c
    end else if (fu[FU_CFU]) begin
        case (uop)
            CFU_JALR: e.opr_a = {sum[31:1], 1'b0};
            CFU_JALI: e.opr_a = {c[31:1], 1'b0};
            default: begin                        // Conditional branch
                e.opr_a = {c[31:1], 1'b0};
                e.uop   = branch_taken(uop, a, b) ? CFU_TAKEN : CFU_NOT_TAKEN;
            end
        endcase
    end else begin
        e.ld_b = 1'b1;                            // CSR keeps opr_a, opr_c into opr_b
    end
    return e;
endfunction

`endif

//--- sim/tb_execute.sv
/*
 * Testbench for the execute stage. Random instructions from a fixed seed,
 * random writeback back-pressure, flushes and aborted multiplies, all
 * checked in order at s3 against the reference model.
 */
`timescale 1ns/1ps

module tb_execute;
    import frv_exec_pkg::*;

    `include "exec_model.svh"

    localparam int   TIMEOUT = 200;               // Cycles allowed per wait
    localparam uop_t CFU_OPS [8] = '{CFU_BEQ, CFU_BNE, CFU_BLT, CFU_BGE,
                                     CFU_BLTU, CFU_BGEU, CFU_JALR, CFU_JALI};

    logic        g_clk = 1'b0;
    logic        g_resetn;
    logic        i_s2_valid;
    logic [4:0]  i_s2_rd;
    xword_t      i_s2_opr_a;
    xword_t      i_s2_opr_b;
    xword_t      i_s2_opr_c;
    uop_t        i_s2_uop;
    fu_t         i_s2_fu;
    logic [1:0]  i_s2_size;
    logic [31:0] i_s2_instr;
    logic        o_s2_busy;
    logic        i_flush;
    logic        o_s3_valid;
    logic [4:0]  o_s3_rd;
    xword_t      o_s3_opr_a;
    xword_t      o_s3_opr_b;
    uop_t        o_s3_uop;
    fu_t         o_s3_fu;
    logic [1:0]  o_s3_size;
    logic [31:0] o_s3_instr;
    logic        i_s3_busy;
    logic [4:0]  o_fwd_rd;
    xword_t      o_fwd_wdata;
    logic        o_fwd_load;
    logic        o_fwd_csr;

    integer      seed = 32'he0e9;
    int          errors = 0;
    int          timeouts = 0;
    logic        bp_en = 1'b0;                    // Random i_s3_busy
    expect_t     exp_q[$];                        // Issued, not yet seen at s3
    xword_t      last_b;                          // opr_b register contents
    logic        last_b_known = 1'b0;
    logic        held = 1'b0;                     // s3 item stalled last cycle
    expect_t     held_e;                          // s3 outputs seen last cycle

    frv_pipeline_execute u_dut (.*);

    always #4 g_clk = ~g_clk;

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got === exp) else begin
            $display("FAILED %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic compare_s3(input expect_t e);
        check_value("o_s3_rd", o_s3_rd, e.rd);
        check_value("o_s3_uop", o_s3_uop, e.uop);
        check_value("o_s3_fu", o_s3_fu, e.fu);
        check_value("o_s3_size", o_s3_size, e.size);
        check_value("o_s3_instr", o_s3_instr, e.instr);
        check_value("o_s3_opr_a", o_s3_opr_a, e.opr_a);
        if (e.chk_b) check_value("o_s3_opr_b", o_s3_opr_b, e.opr_b);
    endtask

    // Monitor ----------------------------------------------------------------
    // Runs mid-cycle, so everything seen here holds through the next edge
    always @(negedge g_clk) begin : monitor
        expect_t e;
        if (g_resetn) begin
            if (o_s3_valid && !i_s3_busy) begin   // Writeback takes the item
                assert (exp_q.size() != 0) else begin
                    $display("an instruction reached s3 that was never issued");
                    errors++;
                end
                if (exp_q.size() != 0) compare_s3(exp_q.pop_front());
            end
            if (held) begin                       // Stalled item must not move
                check_value("o_s3_valid", o_s3_valid, 1'b1);
                compare_s3(held_e);
            end
            held   = o_s3_valid && i_s3_busy;
            held_e = '{rd: o_s3_rd, uop: o_s3_uop, fu: o_s3_fu, size: o_s3_size,
                       instr: o_s3_instr, opr_a: o_s3_opr_a, opr_b: o_s3_opr_b,
                       ld_b: 1'b0, chk_b: 1'b1};
            if (i_s2_valid && !i_s2_fu[FU_MUL])   // Single cycle units stall on s3 only
                check_value("o_s2_busy", o_s2_busy, o_s3_valid && i_s3_busy);
            if (i_s2_valid && !o_s2_busy) begin   // Progress
                e = expect_result(i_s2_rd, i_s2_opr_a, i_s2_opr_b, i_s2_opr_c, i_s2_uop,
                                  i_s2_fu, i_s2_size, i_s2_instr);
                if (e.ld_b) begin
                    last_b       = e.opr_b;
                    last_b_known = 1'b1;
                end
                e.opr_b = last_b;
                e.chk_b = last_b_known;
                check_value("o_fwd_rd", o_fwd_rd, e.rd);
                check_value("o_fwd_wdata", o_fwd_wdata, e.opr_a);
                check_value("o_fwd_load", o_fwd_load, i_s2_fu[FU_LSU] && i_s2_uop[LSU_LOAD]);
                check_value("o_fwd_csr", o_fwd_csr, i_s2_fu[FU_CSR]);
                exp_q.push_back(e);
            end
            if (i_flush) begin                    // Everything in flight is dropped
                exp_q.delete();
                held = 1'b0;
            end
        end
    end

    // Stimulus ---------------------------------------------------------------
    task automatic next_cycle();
        @(posedge g_clk);
        #1;
        i_s3_busy = bp_en ? 1'($random(seed)) : 1'b0;
    endtask

    // Hold the instruction until the stage takes it
    task automatic present();
        int waited;
        if (timeouts == 0) begin
            i_s2_valid = 1'b1;
            waited     = 0;
            @(negedge g_clk);
            if (i_s2_fu[FU_MUL]) check_value("o_s2_busy", o_s2_busy, 1'b1);
            while (o_s2_busy && waited < TIMEOUT) begin
                next_cycle();
                @(negedge g_clk);
                waited++;
            end
            assert (!o_s2_busy) else begin
                $display("timed out waiting for the stage to accept an instruction");
                timeouts++;
            end
            next_cycle();
            i_s2_valid = 1'b0;
            if (({$random(seed)} % 4) == 0) next_cycle();   // Idle gap
        end
    endtask

    task automatic issue_random();
        int  kind;
        logic store;
        kind       = {$random(seed)} % 20;
        i_s2_rd    = $random(seed);
        i_s2_opr_a = $random(seed);
        i_s2_opr_b = $random(seed);
        i_s2_opr_c = $random(seed);
        i_s2_size  = $random(seed);
        i_s2_instr = $random(seed);
        if (({$random(seed)} % 4) == 0) i_s2_opr_b = i_s2_opr_a;   // Hit the equal cases
        i_s2_fu = '0;
        if (kind < 8) begin
            i_s2_fu[FU_ALU] = 1'b1;
            i_s2_uop        = {$random(seed)} % 10;
        end else if (kind < 12) begin
            i_s2_fu[FU_CFU] = 1'b1;
            i_s2_uop        = CFU_OPS[{$random(seed)} % 8];
        end else if (kind < 15) begin
            i_s2_fu[FU_LSU] = 1'b1;
            store           = $random(seed);
            i_s2_uop        = {store, !store, 3'($random(seed))};
        end else if (kind < 17) begin
            i_s2_fu[FU_CSR] = 1'b1;
            i_s2_uop        = $random(seed);
        end else begin
            i_s2_fu[FU_MUL] = 1'b1;
            i_s2_uop        = {$random(seed)} % 4;
        end
        present();
    endtask

    // Flush, optionally while a multiply is still running
    task automatic flush_stage(input logic abort_mul);
        int n;
        if (abort_mul) begin
            i_s2_fu         = '0;
            i_s2_fu[FU_MUL] = 1'b1;
            i_s2_uop        = MUL_MULH;
            i_s2_valid      = 1'b1;
            n               = 2 + {$random(seed)} % 8;   // Well short of completion
            repeat (n) next_cycle();
        end
        i_s2_valid = 1'b0;
        i_flush    = 1'b1;
        next_cycle();
        i_flush = 1'b0;
        @(negedge g_clk);
        check_value("o_s3_valid", o_s3_valid, 1'b0);
        next_cycle();                             // Back to the drive point
    endtask

    initial begin
        int waited;
        g_resetn   = 1'b0;
        i_s2_valid = 1'b0;
        i_s2_rd    = '0;
        i_s2_opr_a = '0;
        i_s2_opr_b = '0;
        i_s2_opr_c = '0;
        i_s2_uop   = '0;
        i_s2_fu    = '0;
        i_s2_size  = '0;
        i_s2_instr = '0;
        i_flush    = 1'b0;
        i_s3_busy  = 1'b0;
        repeat (16) @(posedge g_clk);
        #1 g_resetn = 1'b1;
        @(negedge g_clk);
        check_value("o_s3_valid", o_s3_valid, 1'b0);
        check_value("o_s2_busy", o_s2_busy, 1'b0);
        next_cycle();

        repeat (300) issue_random();              // Free-running writeback
        bp_en = 1'b1;
        repeat (300) issue_random();              // Random back-pressure
        for (int r = 0; r < 12; r++) begin
            repeat (3) issue_random();
            flush_stage(r[0]);
        end
        repeat (50) issue_random();

        waited = 0;
        while (exp_q.size() != 0 && waited < TIMEOUT) begin
            next_cycle();
            waited++;
        end
        assert (exp_q.size() == 0) else begin
            $display("%0d issued instructions never reached s3", exp_q.size());
            errors++;
        end

        $display("errors %0d, timeouts %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- flist.f
+incdir+sim
common/frv_exec_pkg.sv
common/alu_if.sv
common/imul_if.sv
verilog/frv_alu.sv
imul/frv_imul.sv
verilog/frv_exec_select.sv
verilog/frv_pipeline_register.sv
verilog/frv_pipeline_execute.sv
sim/tb_execute.sv
